//--- source/crc24_pkg.sv
// CRC24 constants and widths for the stream datapath
// polynomial, initial value and word size of the non-reflected CRC
// plain vector typedefs for a CRC state and a data word

package crc24_pkg;

	//////////////////////////////
	// widths

	// bits in one CRC state or contribution
	localparam int CRC_BITS = 24;

	// bits in one stream data word
	localparam int WORD_BITS = 64;

	//////////////////////////////
	// polynomial and seed

	// generator x^24 + x^21 + x^20 + x^17 + x^15 + x^11 + x^9 + x^8 + x^6 + x^5 + x + 1
	// with the implicit x^24 term left out
	localparam logic [CRC_BITS-1:0] CRC24_POLY = 24'h328b63;

	// every packet starts from the all-ones state
	localparam logic [CRC_BITS-1:0] CRC24_INIT = 24'hffffff;

	//////////////////////////////
	// vector types

	// a CRC state, or the contribution of one word to a CRC
	typedef logic [CRC_BITS-1:0] crc24_t;

	// one data word of the stream, bit 63 is sent first
	typedef logic [WORD_BITS-1:0] word_t;

endpackage

//--- source/stream_pkg.sv
// stream side types for the CRC24 datapath
// input beat struct, combiner term struct and the coverage count

package stream_pkg;

	// number of earlier words of the packet folded in by the combiner
	// it saturates at two, since older words arrive through the rolling CRC
	typedef logic [1:0] covered_t;

	// highest value the coverage count takes
	localparam covered_t COVERED_MAX = 2'd2;

	// one word on the input, with its framing strobes
	// sop and eop are both set on a single-word packet
	typedef struct packed {
		crc24_pkg::word_t data;
		logic valid;
		logic sop;
		logic eop;
	} beat_t;

	// everything the combiner needs for one word
	// contrib_0 belongs to the current word, contrib_n1 to the one before it
	typedef struct packed {
		crc24_pkg::crc24_t contrib_0;
		crc24_pkg::crc24_t contrib_n1;
		covered_t covered;
		logic valid;
		logic last;
	} term_t;

endpackage

//--- source/crc24_zero_advance.sv
// advance of a CRC24 state over a run of all-zero words
// pure XOR network, the run length is a parameter

`timescale 1ns/1ps

module crc24_zero_advance #(
	// number of 64-bit zero words the state is pushed through
	parameter int ADV_WORDS = 1
) (
	input crc24_pkg::crc24_t c,
	output crc24_pkg::crc24_t crc_out
);
	import crc24_pkg::*;

	// pushes one state through n zero bits of the division
	// with a zero data bit the feedback is just the state msb
	function automatic crc24_t advance_zero(input crc24_t seed, input int n_bits);
		crc24_t s;
		s = seed;
		for (int i = 0; i < n_bits; i++) begin
			if (s[CRC_BITS-1]) begin
				s = {s[CRC_BITS-2:0], 1'b0} ^ CRC24_POLY;
			end else begin
				s = {s[CRC_BITS-2:0], 1'b0};
			end
		end
		return s;
	endfunction

	//////////////////////////////
	// unrolled advance

	// the loop bound is constant, so this flattens to a 24x24 XOR matrix
	// when c is a constant the whole block folds to a constant too
	always_comb begin
		crc_out = advance_zero(c, ADV_WORDS * WORD_BITS);
	end

endmodule

//--- source/crc24_word_contrib.sv
// first stage of the CRC24 stream datapath
// registers the zero-seeded CRC24 of each input word
// and delays the beat strobes by the same single cycle

`timescale 1ns/1ps

module crc24_word_contrib (
	input logic clk,
	input logic arst,
	input logic ena,
	input stream_pkg::beat_t beat,
	output crc24_pkg::crc24_t contrib,
	output logic valid,
	output logic sop,
	output logic eop
);
	import crc24_pkg::*;

	crc24_t word_crc;

	// serial division of the word alone, msb first, starting from zero
	// the seed and the earlier words are added back in by the combiner
	always_comb begin
		word_crc = '0;
		for (int i = WORD_BITS - 1; i >= 0; i--) begin
			if (word_crc[CRC_BITS-1] ^ beat.data[i]) begin
				word_crc = {word_crc[CRC_BITS-2:0], 1'b0} ^ CRC24_POLY;
			end else begin
				word_crc = {word_crc[CRC_BITS-2:0], 1'b0};
			end
		end
	end

	// zero-seeded CRC of the word taken on this edge
	always_ff @(posedge clk) begin
		if (ena) begin
			contrib <= word_crc;
		end
	end

	// strobes line up with the registered contribution
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			valid <= 1'b0;
			sop <= 1'b0;
			eop <= 1'b0;
		end else if (ena) begin
			valid <= beat.valid;
			sop <= beat.sop;
			eop <= beat.eop;
		end
	end

	// the source must not frame a word it does not send
	a_flags_need_valid : assert property (@(posedge clk) disable iff (arst)
		ena && (beat.sop || beat.eop) |-> beat.valid);

endmodule

//--- source/crc24_term_sequencer.sv
// middle stage of the CRC24 stream datapath
// counts words within a packet, keeps the previous contribution
// and assembles the term struct for the combiner

`timescale 1ns/1ps

module crc24_term_sequencer (
	input logic clk,
	input logic arst,
	input logic ena,
	input crc24_pkg::crc24_t contrib,
	input logic valid,
	input logic sop,
	input logic eop,
	output stream_pkg::term_t term
);
	import crc24_pkg::*;
	import stream_pkg::*;

	// contribution of the last accepted word
	crc24_t prev_q;

	// words of the current packet seen so far, saturating
	covered_t count_q;

	// set while a packet has started and its eop has not arrived
	logic open_q;

	//////////////////////////////
	// packet position

	// sop restarts the count, so the word after it sees one earlier word
	// beyond two the count holds, older words ride in the rolling CRC
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			count_q <= '0;
			open_q <= 1'b0;
		end else if (ena && valid) begin
			if (sop) begin
				count_q <= covered_t'(1);
			end else if (count_q != COVERED_MAX) begin
				count_q <= count_q + covered_t'(1);
			end
			open_q <= !eop;
		end
	end

	always_ff @(posedge clk) begin
		if (ena && valid) begin
			prev_q <= contrib;
		end
	end

	//////////////////////////////
	// term assembly

	// purely combinational, the combiner registers it on the next edge
	always_comb begin
		term.contrib_0 = contrib;
		term.contrib_n1 = prev_q;
		term.covered = sop ? covered_t'(0) : count_q;
		term.valid = valid;
		term.last = valid & eop;
	end

	// the rolling CRC only works if a packet has no holes in it
	a_no_gap_in_packet : assert property (@(posedge clk) disable iff (arst)
		ena && open_q |-> valid);

	// a new packet may only start once the previous one has ended
	a_sop_when_closed : assert property (@(posedge clk) disable iff (arst)
		ena && valid && sop |-> !open_q);

endmodule

//--- source/crc24_combine_upto3.sv
// last stage of the CRC24 stream datapath
// adds the current contribution, the advanced previous one, and either
// the advanced seed or the rolling CRC of two words back

`timescale 1ns/1ps

module crc24_combine_upto3 (
	input logic clk,
	input logic arst,
	input logic ena,
	input stream_pkg::term_t term,
	output crc24_pkg::crc24_t crc,
	output logic crc_valid,
	output logic crc_last
);
	import crc24_pkg::*;
	import stream_pkg::*;

	crc24_t init_adv1, init_adv2;
	crc24_t prev_adv1, roll_adv2;
	crc24_t contrib_q, prev_adv_q, roll_q;
	crc24_t base_term;
	covered_t covered_q;
	logic valid_q, last_q;
	logic crc_valid_q, crc_last_q;

	//////////////////////////////
	// advanced terms

	// the seed advanced by one and two words, both fold to constants
	crc24_zero_advance #(.ADV_WORDS(1)) init_a1 (.c(CRC24_INIT), .crc_out(init_adv1));
	crc24_zero_advance #(.ADV_WORDS(2)) init_a2 (.c(CRC24_INIT), .crc_out(init_adv2));

	// previous word moved up past the current one
	crc24_zero_advance #(.ADV_WORDS(1)) prev_a1 (.c(term.contrib_n1), .crc_out(prev_adv1));

	// the result on crc right now belongs to the word two ahead of stage 2
	// so it is moved past the two words in between
	crc24_zero_advance #(.ADV_WORDS(2)) roll_a2 (.c(crc), .crc_out(roll_adv2));

	//////////////////////////////
	// stage 1

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			covered_q <= '0;
			valid_q <= 1'b0;
			last_q <= 1'b0;
		end else if (ena) begin
			covered_q <= term.covered;
			valid_q <= term.valid;
			last_q <= term.last;
		end
	end

	// first word of a packet has no predecessor to fold in
	always_ff @(posedge clk) begin
		if (ena) begin
			contrib_q <= term.contrib_0;
			prev_adv_q <= (term.covered == covered_t'(0)) ? '0 : prev_adv1;
			roll_q <= roll_adv2;
		end
	end

	// words 0 and 1 still carry the seed, later words get it via the rolling CRC
	always_comb begin
		case (covered_q)
			2'd0: base_term = init_adv1;
			2'd1: base_term = init_adv2;
			default: base_term = roll_q;
		endcase
	end

	//////////////////////////////
	// stage 2

	// crc holds its value between words, which is what feeds roll_q
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			crc <= CRC24_INIT;
			crc_valid_q <= 1'b0;
			crc_last_q <= 1'b0;
		end else if (ena) begin
			crc_valid_q <= valid_q;
			crc_last_q <= valid_q & last_q;
			if (valid_q) begin
				crc <= contrib_q ^ prev_adv_q ^ base_term;
			end
		end
	end

	// a held result only counts once the pipeline moves again
	assign crc_valid = crc_valid_q & ena;
	assign crc_last = crc_last_q & ena;

	// any word past the first needs the previous result to be on crc now
	a_rolling_in_place : assert property (@(posedge clk) disable iff (arst)
		ena && valid_q && covered_q != covered_t'(0) |-> crc_valid_q);

endmodule

//--- source/crc24_stream_top.sv
// top of the CRC24 stream datapath
// word contribution, term sequencing and combining in series
// three enabled cycles from an accepted beat to its result

`timescale 1ns/1ps

module crc24_stream_top (
	input logic clk,
	input logic arst,
	input logic ena,
	input stream_pkg::beat_t beat,
	output crc24_pkg::crc24_t crc,
	output logic crc_valid,
	output logic crc_last
);
	import crc24_pkg::*;
	import stream_pkg::*;

	// stage 1 to stage 2
	crc24_t contrib;
	logic contrib_valid;
	logic contrib_sop;
	logic contrib_eop;

	// stage 2 to stage 3
	term_t term;

	//////////////////////////////
	// per-word CRC

	crc24_word_contrib contrib0 (
		.clk(clk),
		.arst(arst),
		.ena(ena),
		.beat(beat),
		.contrib(contrib),
		.valid(contrib_valid),
		.sop(contrib_sop),
		.eop(contrib_eop)
	);

	//////////////////////////////
	// packet position and terms

	crc24_term_sequencer seq0 (
		.clk(clk),
		.arst(arst),
		.ena(ena),
		.contrib(contrib),
		.valid(contrib_valid),
		.sop(contrib_sop),
		.eop(contrib_eop),
		.term(term)
	);

	//////////////////////////////
	// running CRC

	crc24_combine_upto3 comb0 (
		.clk(clk),
		.arst(arst),
		.ena(ena),
		.term(term),
		.crc(crc),
		.crc_valid(crc_valid),
		.crc_last(crc_last)
	);

endmodule

//--- testbench/tb_crc24_stream.sv
// testbench for the CRC24 stream datapath
// packet table walked in a loop, random data words and random ena stalls
// bit-serial reference CRC, result monitor, error counting and watchdog

`timescale 1ns/1ps

module tb_crc24_stream;
	import crc24_pkg::*;
	import stream_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int HALF_PERIOD = CLK_PERIOD / 2;
	localparam int RESET_CYCLES = 5;
	localparam int NUM_PKTS = 16;
	// longest run of stalled cycles in a row
	localparam int MAX_STALL = 3;
	// idle cycles after the last result, to catch stray pulses
	localparam int IDLE_TAIL = 8;
	localparam logic [31:0] SEED = 32'h2480c045;

	// one table row, a packet and what follows it
	typedef struct packed {
		int unsigned len;
		int unsigned gap;
		logic may_stall;
	} pkt_entry_t;

	logic clk;
	logic arst;
	logic ena;
	beat_t beat;
	crc24_t crc;
	logic crc_valid;
	logic crc_last;

	pkt_entry_t pkt_table [NUM_PKTS];
	crc24_t exp_crc_q [$];
	logic exp_last_q [$];
	int unsigned total_words;
	int unsigned pulse_count;
	int unsigned stall_count;
	int unsigned check_count;
	int unsigned error_count;
	int stall_run;

	crc24_stream_top dut0 (
		.clk(clk),
		.arst(arst),
		.ena(ena),
		.beat(beat),
		.crc(crc),
		.crc_valid(crc_valid),
		.crc_last(crc_last)
	);

	always #HALF_PERIOD clk = ~clk;

	//////////////////////////////
	// reference and checking

	// non-reflected CRC24, msb of the word first, no final inversion
	function automatic crc24_t serial_crc_word(input crc24_t state, input word_t data);
		crc24_t s;
		logic fb;
		s = state;
		for (int i = WORD_BITS - 1; i >= 0; i--) begin
			fb = s[23] ^ data[i];
			s = {s[22:0], 1'b0};
			if (fb) begin
				s = s ^ CRC24_POLY;
			end
		end
		return s;
	endfunction

	task automatic check_value(input string what, input logic [63:0] got,
		input logic [63:0] expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("** Error: %0d ns: %s is %0h, expected %0h", $time, what, got, expected);
		end
	endtask

	task automatic print_counts();
		$display("words %0d, results %0d, stall cycles %0d, checks %0d, errors %0d",
			total_words, pulse_count, stall_count, check_count, error_count);
	endtask

	// every result must come with ena high and in word order
	always @(posedge clk) begin
		crc24_t exp_crc;
		logic exp_last;
		if (!arst) begin
			if (crc_valid && !ena) begin
				error_count++;
				$display("at %0d ns a crc_valid pulse came while ena was low", $time);
			end
			if (crc_last && !crc_valid) begin
				error_count++;
				$display("at %0d ns crc_last was high without crc_valid", $time);
			end
			if (crc_valid) begin
				if (exp_crc_q.size() == 0) begin
					error_count++;
					$display("at %0d ns a crc_valid pulse came with no word outstanding", $time);
				end else begin
					exp_crc = exp_crc_q.pop_front();
					exp_last = exp_last_q.pop_front();
					check_value($sformatf("crc of result %0d", pulse_count),
						64'(crc), 64'(exp_crc));
					check_value($sformatf("crc_last of result %0d", pulse_count),
						64'(crc_last), 64'(exp_last));
				end
				pulse_count++;
			end
		end
	end

	//////////////////////////////
	// stimulus

	// single words, short packets, long back-to-back runs, then stalls
	task automatic load_table();
		pkt_table[0] = '{32'd1, 32'd2, 1'b0};
		pkt_table[1] = '{32'd1, 32'd0, 1'b0};
		pkt_table[2] = '{32'd1, 32'd1, 1'b0};
		pkt_table[3] = '{32'd2, 32'd1, 1'b0};
		pkt_table[4] = '{32'd3, 32'd0, 1'b0};
		pkt_table[5] = '{32'd2, 32'd3, 1'b0};
		pkt_table[6] = '{32'd6, 32'd0, 1'b0};
		pkt_table[7] = '{32'd8, 32'd0, 1'b0};
		pkt_table[8] = '{32'd7, 32'd2, 1'b0};
		pkt_table[9] = '{32'd5, 32'd1, 1'b1};
		pkt_table[10] = '{32'd1, 32'd2, 1'b1};
		pkt_table[11] = '{32'd9, 32'd0, 1'b1};
		pkt_table[12] = '{32'd3, 32'd2, 1'b1};
		pkt_table[13] = '{32'd12, 32'd1, 1'b0};
		pkt_table[14] = '{32'd4, 32'd0, 1'b1};
		pkt_table[15] = '{32'd1, 32'd0, 1'b0};
	endtask

	// worst case assumes every driven cycle of a stall row stalls as long as allowed
	function automatic int unsigned watchdog_cycles();
		int unsigned cycles;
		cycles = RESET_CYCLES + IDLE_TAIL + 20;
		for (int p = 0; p < NUM_PKTS; p++) begin
			if (pkt_table[p].may_stall) begin
				cycles += (pkt_table[p].len + pkt_table[p].gap) * (MAX_STALL + 1);
			end else begin
				cycles += pkt_table[p].len + pkt_table[p].gap;
			end
		end
		return cycles;
	endfunction

	task automatic run_watchdog(input int unsigned limit_cycles);
		#(limit_cycles * CLK_PERIOD);
		$display("watchdog expired after %0d clock cycles, %0d of %0d results seen",
			limit_cycles, pulse_count, total_words);
		print_counts();
		$display("TEST FAIL");
		$finish;
	endtask

	// a stall never lasts more than MAX_STALL cycles in a row
	function automatic logic pick_ena(input logic may_stall);
		if (may_stall && stall_run < MAX_STALL && ($urandom % 3) == 0) begin
			stall_run++;
			stall_count++;
			return 1'b0;
		end
		stall_run = 0;
		return 1'b1;
	endfunction

	// holds the beat on the falling edge until an enabled rising edge takes it
	task automatic drive_cycle(input beat_t b, input logic may_stall);
		logic accepted;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clk);
			beat = b;
			ena = pick_ena(may_stall);
			accepted = ena;
		end
	endtask

	task automatic send_packet(input pkt_entry_t entry);
		beat_t b;
		crc24_t state;
		state = CRC24_INIT;
		for (int unsigned w = 0; w < entry.len; w++) begin
			b.data = {$urandom, $urandom};
			b.valid = 1'b1;
			b.sop = (w == 0);
			b.eop = (w == entry.len - 1);
			// expected running CRC over the words of the packet so far
			state = serial_crc_word(state, b.data);
			exp_crc_q.push_back(state);
			exp_last_q.push_back(b.eop);
			drive_cycle(b, entry.may_stall);
		end
		// gap cycles are counted as driven cycles, stalled or not
		for (int unsigned g = 0; g < entry.gap; g++) begin
			@(negedge clk);
			beat = '0;
			ena = pick_ena(entry.may_stall);
		end
	endtask

	//////////////////////////////
	// main sequence

	initial begin
		clk = 1'b0;
		arst = 1'b1;
		ena = 1'b0;
		beat = '0;
		total_words = 0;
		pulse_count = 0;
		stall_count = 0;
		check_count = 0;
		error_count = 0;
		stall_run = 0;
		void'($urandom(SEED));
		load_table();
		for (int p = 0; p < NUM_PKTS; p++) begin
			total_words += pkt_table[p].len;
		end
		fork
			run_watchdog(watchdog_cycles());
		join_none

		repeat (RESET_CYCLES) @(negedge clk);
		arst = 1'b0;
		ena = 1'b1;
		@(negedge clk);
		// reset values, before any word enters
		check_value("crc after reset", 64'(crc), 64'(CRC24_INIT));
		check_value("crc_valid after reset", 64'(crc_valid), 64'd0);
		check_value("crc_last after reset", 64'(crc_last), 64'd0);

		for (int p = 0; p < NUM_PKTS; p++) begin
			send_packet(pkt_table[p]);
		end

		// drain the pipeline with idle beats at full enable
		@(negedge clk);
		beat = '0;
		ena = 1'b1;
		wait (pulse_count == total_words);
		repeat (IDLE_TAIL) @(negedge clk);

		check_value("crc_valid pulse count", 64'(pulse_count), 64'(total_words));
		check_value("words left without a result", 64'(exp_crc_q.size()), 64'd0);
		print_counts();
		if (error_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

//--- verilog.f
source/crc24_pkg.sv
source/stream_pkg.sv
source/crc24_zero_advance.sv
source/crc24_word_contrib.sv
source/crc24_term_sequencer.sv
source/crc24_combine_upto3.sv
source/crc24_stream_top.sv
testbench/tb_crc24_stream.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP = tb_crc24_stream
FILELIST = verilog.f
OBJ_DIR = obj_dir
LOG = sim.log
FAIL_MSG = TEST FAIL

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
